/* verilog/dualCachePkg.sv */
package dualCachePkg;

  // ##################################################################
  // Cache geometry
  // ##################################################################

  localparam int ADDR_WIDTH       = 32; // Byte address.
  localparam int LINE_OFFSET_BITS = 6;  // 64 bytes per line.
  localparam int INDEX_BITS       = 2;
  localparam int NUM_LINES        = 4;
  localparam int TAG_WIDTH        = 24; // ADDR_WIDTH - INDEX_BITS - LINE_OFFSET_BITS.
  localparam int WORDS_PER_LINE   = 16;
  localparam int WORD_SEL_BITS    = 4;

  // Address field positions follow from the geometry above.
  localparam int INDEX_LSB = LINE_OFFSET_BITS;
  localparam int TAG_LSB   = LINE_OFFSET_BITS + INDEX_BITS;

  // ##################################################################
  // Miss controller states
  // ##################################################################

  // WriteBack and Refill issue one memory strobe each. The two wait
  // states hold until the matching response pulse arrives.
  typedef enum logic [2:0] {
    Idle,
    WriteBack,
    WbWait,
    Refill,
    RefillWait,
    Commit
  } missState_t;

endpackage

/* verilog/cacheLine.sv */
`timescale 1ns/100ps

module cacheLine
  import dualCachePkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic [ADDR_WIDTH-1:0]    rd0Addr,
  input  logic [ADDR_WIDTH-1:0]    rd1Addr,
  output logic [31:0]              rd0Data,
  output logic                     rd0Hit,
  output logic [31:0]              rd1Data,
  output logic                     rd1Hit,

  output logic                     lineValid,
  output logic                     lineDirty,
  output logic [TAG_WIDTH-1:0]     lineTag,

  input  logic                     write,
  input  logic [WORD_SEL_BITS-1:0] wrWord,
  input  logic [TAG_WIDTH-1:0]     wrTag,
  input  logic                     wrValid,
  input  logic                     wrDirty,
  input  logic [31:0]              wrData,
  input  logic [3:0]               wrByteEnable,
  output logic [31:0]              lkupData
);

  logic [31:0]              words [WORDS_PER_LINE];
  logic                     valid;
  logic                     dirty;
  logic [TAG_WIDTH-1:0]     tag;
  logic [WORD_SEL_BITS-1:0] rd0Word;
  logic [WORD_SEL_BITS-1:0] rd1Word;

  assign rd0Word = rd0Addr[LINE_OFFSET_BITS-1:2];
  assign rd1Word = rd1Addr[LINE_OFFSET_BITS-1:2];

  // The index was already matched by the line array, so only the tag is compared here.
  assign rd0Hit  = valid && (tag == rd0Addr[ADDR_WIDTH-1:TAG_LSB]);
  assign rd0Data = words[rd0Word];
  assign rd1Hit  = valid && (tag == rd1Addr[ADDR_WIDTH-1:TAG_LSB]);
  assign rd1Data = words[rd1Word];

  assign lineValid = valid;
  assign lineDirty = dirty;
  assign lineTag   = tag;

  assign lkupData = words[wrWord]; // Victim word during writeback.

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid <= 1'b0;
      dirty <= 1'b0;
      tag   <= '0;
      for (int i = 0; i < WORDS_PER_LINE; i++) begin
        words[i] <= '0;
      end
    end else if (write) begin
      valid <= wrValid;
      dirty <= wrDirty;
      tag   <= wrTag;
      // Only the enabled bytes of the selected word change.
      for (int b = 0; b < 4; b++) begin
        if (wrByteEnable[b]) begin
          words[wrWord][b*8 +: 8] <= wrData[b*8 +: 8];
        end
      end
    end
  end

endmodule

/* verilog/lineArray.sv */
`timescale 1ns/100ps

module lineArray
  import dualCachePkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic [ADDR_WIDTH-1:0]    rd0Addr,
  input  logic [ADDR_WIDTH-1:0]    rd1Addr,
  input  logic [ADDR_WIDTH-1:0]    stAddr,
  output logic [31:0]              rd0Data,
  output logic                     rd0Hit,
  output logic [31:0]              rd1Data,
  output logic                     rd1Hit,
  output logic                     stHit,

  output logic                     victimDirty,
  output logic [TAG_WIDTH-1:0]     victimTag,
  output logic [31:0]              lkupData,

  input  logic                     write,
  input  logic [INDEX_BITS-1:0]    wrIndex,
  input  logic [WORD_SEL_BITS-1:0] wrWord,
  input  logic [TAG_WIDTH-1:0]     wrTag,
  input  logic                     wrValid,
  input  logic                     wrDirty,
  input  logic [31:0]              wrData,
  input  logic [3:0]               wrByteEnable
);

  logic [NUM_LINES-1:0]  lineRd0Hit;
  logic [NUM_LINES-1:0]  lineRd1Hit;
  logic [NUM_LINES-1:0]  lineValid;
  logic [NUM_LINES-1:0]  lineDirty;
  logic [NUM_LINES-1:0]  lineWrite;
  logic [31:0]           lineRd0Data [NUM_LINES];
  logic [31:0]           lineRd1Data [NUM_LINES];
  logic [31:0]           lineLkup [NUM_LINES];
  logic [TAG_WIDTH-1:0]  lineTag [NUM_LINES];
  logic [INDEX_BITS-1:0] rd0Index;
  logic [INDEX_BITS-1:0] rd1Index;
  logic [INDEX_BITS-1:0] stIndex;

  assign rd0Index = rd0Addr[INDEX_LSB +: INDEX_BITS];
  assign rd1Index = rd1Addr[INDEX_LSB +: INDEX_BITS];
  assign stIndex  = stAddr[INDEX_LSB +: INDEX_BITS];

  for (genvar i = 0; i < NUM_LINES; i++) begin : gLine
    assign lineWrite[i] = write && (wrIndex == INDEX_BITS'(i)); // Steer the strobe to one line.

    cacheLine line (
      .clk          (clk),
      .rst_n        (rst_n),
      .rd0Addr      (rd0Addr),
      .rd1Addr      (rd1Addr),
      .rd0Data      (lineRd0Data[i]),
      .rd0Hit       (lineRd0Hit[i]),
      .rd1Data      (lineRd1Data[i]),
      .rd1Hit       (lineRd1Hit[i]),
      .lineValid    (lineValid[i]),
      .lineDirty    (lineDirty[i]),
      .lineTag      (lineTag[i]),
      .write        (lineWrite[i]),
      .wrWord       (wrWord),
      .wrTag        (wrTag),
      .wrValid      (wrValid),
      .wrDirty      (wrDirty),
      .wrData       (wrData),
      .wrByteEnable (wrByteEnable),
      .lkupData     (lineLkup[i])
    );
  end

  assign rd0Hit  = lineRd0Hit[rd0Index];
  assign rd0Data = lineRd0Data[rd0Index];
  assign rd1Hit  = lineRd1Hit[rd1Index];
  assign rd1Data = lineRd1Data[rd1Index];

  assign stHit = lineValid[stIndex] && (lineTag[stIndex] == stAddr[ADDR_WIDTH-1:TAG_LSB]);

  // Victim view follows the line the controller is addressing.
  assign victimDirty = lineValid[wrIndex] && lineDirty[wrIndex];
  assign victimTag   = lineTag[wrIndex];
  assign lkupData    = lineLkup[wrIndex];

endmodule

/* verilog/missController.sv */
`timescale 1ns/100ps

module missController
  import dualCachePkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     rd0Req,
  input  logic [ADDR_WIDTH-1:0]    rd0Addr,
  input  logic                     rd0Hit,
  input  logic                     rd1Req,
  input  logic [ADDR_WIDTH-1:0]    rd1Addr,
  input  logic                     rd1Hit,

  input  logic                     stReq,
  input  logic [ADDR_WIDTH-1:0]    stAddr,
  input  logic [31:0]              stData,
  input  logic [3:0]               stByteEnable,
  input  logic                     stHit,
  output logic                     stDone,
  output logic                     busy,

  input  logic                     victimDirty,
  input  logic [TAG_WIDTH-1:0]     victimTag,
  input  logic [31:0]              lkupData,

  output logic                     write,
  output logic [INDEX_BITS-1:0]    wrIndex,
  output logic [WORD_SEL_BITS-1:0] wrWord,
  output logic [TAG_WIDTH-1:0]     wrTag,
  output logic                     wrValid,
  output logic                     wrDirty,
  output logic [31:0]              wrData,
  output logic [3:0]               wrByteEnable,

  output logic                     memRead,
  output logic                     memWrite,
  output logic [ADDR_WIDTH-3:0]    memAddr,
  output logic [31:0]              memWrData,
  input  logic [31:0]              memRdData,
  input  logic                     memRdValid,
  input  logic                     memWrAck
);

  missState_t               state;
  missState_t               nextState;
  logic [WORD_SEL_BITS-1:0] wordCnt;
  logic                     serveStore;
  logic                     lastWord;
  logic                     missSeen;
  logic [ADDR_WIDTH-1:0]    selAddr;
  logic [TAG_WIDTH-1:0]     reqTag;
  logic [INDEX_BITS-1:0]    reqIndex;
  logic [WORD_SEL_BITS-1:0] reqWord;

  assign lastWord = (wordCnt == WORD_SEL_BITS'(WORDS_PER_LINE - 1));

  // ##################################################################
  // Request selection in the order store, port 0, port 1
  // ##################################################################

  always_comb begin
    selAddr  = rd1Addr;
    missSeen = 1'b0;
    if (stReq) begin
      selAddr  = stAddr;
      missSeen = !stHit;
    end else if (rd0Req && !rd0Hit) begin
      selAddr  = rd0Addr;
      missSeen = 1'b1;
    end else if (rd1Req && !rd1Hit) begin
      missSeen = 1'b1;
    end
  end

  // ##################################################################
  // State machine
  // ##################################################################

  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (stReq && stHit) nextState = Commit;
        else if (missSeen) nextState = victimDirty ? WriteBack : Refill;
      end
      WriteBack:  nextState = WbWait;
      WbWait:     if (memWrAck) nextState = lastWord ? Refill : WriteBack;
      Refill:     nextState = RefillWait;
      RefillWait: begin
        if (memRdValid) begin
          if (!lastWord) nextState = Refill;
          else nextState = serveStore ? Commit : Idle; // A store miss still has to merge.
        end
      end
      Commit:     nextState = Idle;
      default:    nextState = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= Idle;
      wordCnt    <= '0;
      serveStore <= 1'b0;
    end else begin
      state <= nextState;
      if (state == Idle) begin
        wordCnt    <= '0;
        serveStore <= stReq;
      end else if ((state == WbWait && memWrAck) || (state == RefillWait && memRdValid)) begin
        wordCnt <= wordCnt + 1'b1; // Wraps to zero after the last writeback word.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == Idle) begin
      reqTag   <= selAddr[ADDR_WIDTH-1:TAG_LSB];
      reqIndex <= selAddr[INDEX_LSB +: INDEX_BITS];
      reqWord  <= selAddr[LINE_OFFSET_BITS-1:2];
    end
  end

  // ##################################################################
  // Line write port and memory strobes
  // ##################################################################

  always_comb begin
    // In Idle the victim lookup must already point at the candidate line.
    wrIndex      = (state == Idle) ? selAddr[INDEX_LSB +: INDEX_BITS] : reqIndex;
    write        = 1'b0;
    wrWord       = wordCnt;
    wrTag        = reqTag;
    wrValid      = 1'b0;
    wrDirty      = 1'b0;
    wrData       = memRdData;
    wrByteEnable = 4'hf;
    case (state)
      RefillWait: begin
        write   = memRdValid;
        wrValid = lastWord; // The line turns valid with its last word.
      end
      Commit: begin
        write        = 1'b1;
        wrWord       = reqWord;
        wrValid      = 1'b1;
        wrDirty      = 1'b1;
        wrData       = stData;
        wrByteEnable = stByteEnable;
      end
      default: ;
    endcase
  end

  assign memWrite  = (state == WriteBack);
  assign memRead   = (state == Refill);
  assign memWrData = lkupData;
  assign memAddr   = (state == WriteBack || state == WbWait) ?
                     {victimTag, reqIndex, wordCnt} : {reqTag, reqIndex, wordCnt};

  assign stDone = (state == Commit);
  assign busy   = (state != Idle);

endmodule

/* verilog/dualCache.sv */
`timescale 1ns/100ps

module dualCache
  import dualCachePkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  rd0Req,
  input  logic [ADDR_WIDTH-1:0] rd0Addr,
  output logic [31:0]           rd0Data,
  output logic                  rd0Hit,
  input  logic                  rd1Req,
  input  logic [ADDR_WIDTH-1:0] rd1Addr,
  output logic [31:0]           rd1Data,
  output logic                  rd1Hit,

  input  logic                  stReq,
  input  logic [ADDR_WIDTH-1:0] stAddr,
  input  logic [31:0]           stData,
  input  logic [3:0]            stByteEnable,
  output logic                  stDone,
  output logic                  busy,

  output logic                  memRead,
  output logic                  memWrite,
  output logic [ADDR_WIDTH-3:0] memAddr, // Word address.
  output logic [31:0]           memWrData,
  input  logic [31:0]           memRdData,
  input  logic                  memRdValid,
  input  logic                  memWrAck
);

  logic                     stHit;
  logic                     victimDirty;
  logic [TAG_WIDTH-1:0]     victimTag;
  logic [31:0]              lkupData;
  logic                     write;
  logic [INDEX_BITS-1:0]    wrIndex;
  logic [WORD_SEL_BITS-1:0] wrWord;
  logic [TAG_WIDTH-1:0]     wrTag;
  logic                     wrValid;
  logic                     wrDirty;
  logic [31:0]              wrData;
  logic [3:0]               wrByteEnable;

  lineArray lines (
    .clk, .rst_n,
    .rd0Addr, .rd1Addr, .stAddr,
    .rd0Data, .rd0Hit, .rd1Data, .rd1Hit, .stHit,
    .victimDirty, .victimTag, .lkupData,
    .write, .wrIndex, .wrWord, .wrTag, .wrValid, .wrDirty, .wrData, .wrByteEnable
  );

  missController controller (
    .clk, .rst_n,
    .rd0Req, .rd0Addr, .rd0Hit, .rd1Req, .rd1Addr, .rd1Hit,
    .stReq, .stAddr, .stData, .stByteEnable, .stHit, .stDone, .busy,
    .victimDirty, .victimTag, .lkupData,
    .write, .wrIndex, .wrWord, .wrTag, .wrValid, .wrDirty, .wrData, .wrByteEnable,
    .memRead, .memWrite, .memAddr, .memWrData, .memRdData, .memRdValid, .memWrAck
  );

endmodule

/* verif/dualCacheProps.sv */
`timescale 1ns/100ps

module dualCacheProps (
  input logic clk,
  input logic rst_n,
  input logic memRead,
  input logic memWrite,
  input logic memRdValid,
  input logic memWrAck,
  input logic stReq,
  input logic stDone,
  input logic busy
);

  logic readPending; // A memRead is waiting for its memRdValid.
  logic writePending;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      readPending  <= 1'b0;
      writePending <= 1'b0;
    end else begin
      if (memRead) readPending <= 1'b1;
      else if (memRdValid) readPending <= 1'b0;
      if (memWrite) writePending <= 1'b1;
      else if (memWrAck) writePending <= 1'b0;
    end
  end

  // ####################################################################
  // Memory strobes
  // ####################################################################

  strobesExclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(memRead && memWrite)
  ) else $error("memRead and memWrite are high in the same cycle.");

  oneReadOutstanding: assert property (
    @(posedge clk) disable iff (!rst_n) memRead |-> !readPending
  ) else $error("A new memRead was issued before memRdValid arrived.");

  oneWriteOutstanding: assert property (
    @(posedge clk) disable iff (!rst_n) memWrite |-> !writePending
  ) else $error("A new memWrite was issued before memWrAck arrived.");

  // ####################################################################
  // Host pulses
  // ####################################################################

  doneOnlyWithRequest: assert property (
    @(posedge clk) disable iff (!rst_n) stDone |-> stReq
  ) else $error("stDone is high while stReq is low.");

  idleInReset: assert property (
    @(posedge clk) !rst_n |-> !busy
  ) else $error("busy is high during reset.");

endmodule

bind dualCache dualCacheProps props (
  .clk        (clk),
  .rst_n      (rst_n),
  .memRead    (memRead),
  .memWrite   (memWrite),
  .memRdValid (memRdValid),
  .memWrAck   (memWrAck),
  .stReq      (stReq),
  .stDone     (stDone),
  .busy       (busy)
);

/* verif/dualCacheTb.sv */
`timescale 1ns/100ps

module dualCacheTb
  import dualCachePkg::*;
();

  localparam int MEM_WORDS = 4096;

  typedef enum logic [1:0] {OpRd0, OpRd1, OpDual, OpStore} opKind_t;

  typedef struct {
    opKind_t               op;
    logic [ADDR_WIDTH-1:0] addr;
    logic [ADDR_WIDTH-1:0] addr1; // Port 1 address of a dual read.
    logic [31:0]           data;
    logic [3:0]            be;
    logic                  expHit;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  logic                  rd0Req;
  logic [ADDR_WIDTH-1:0] rd0Addr;
  logic [31:0]           rd0Data;
  logic                  rd0Hit;
  logic                  rd1Req;
  logic [ADDR_WIDTH-1:0] rd1Addr;
  logic [31:0]           rd1Data;
  logic                  rd1Hit;
  logic                  stReq;
  logic [ADDR_WIDTH-1:0] stAddr;
  logic [31:0]           stData;
  logic [3:0]            stByteEnable;
  logic                  stDone;
  logic                  busy;
  logic                  memRead;
  logic                  memWrite;
  logic [ADDR_WIDTH-3:0] memAddr;
  logic [31:0]           memWrData;
  logic [31:0]           memRdData;
  logic                  memRdValid;
  logic                  memWrAck;

  logic [31:0] memWords [MEM_WORDS];
  logic [7:0]  shadow [MEM_WORDS*4]; // Memory contents as the host should see them.
  row_t        rows [$];
  int          memOps;
  int          cycleCount;
  int          timeoutLimit;
  integer      seed = 32'hc538_3a38;

  dualCache dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] fillWord(input int n);
    return (32'(n) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  function automatic logic [31:0] expectedWord(input logic [ADDR_WIDTH-1:0] addr);
    int base;
    base = int'(addr[13:2]) * 4;
    return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
  endfunction

  task automatic loadShadow();
    logic [31:0] word;
    for (int n = 0; n < MEM_WORDS; n++) begin
      word = fillWord(n);
      for (int b = 0; b < 4; b++) begin
        shadow[n*4 + b] = word[b*8 +: 8];
      end
    end
  endtask

  task automatic writeShadow(input logic [ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                             input logic [3:0] be);
    int base;
    base = int'(addr[13:2]) * 4;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) shadow[base + b] = data[b*8 +: 8];
    end
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "Stopping at the first mismatch.");
    end
  endtask

  task automatic addRow(input opKind_t op, input logic [ADDR_WIDTH-1:0] addr,
                        input logic [ADDR_WIDTH-1:0] addr1, input logic [31:0] data,
                        input logic [3:0] be, input logic expHit);
    row_t r;
    r.op     = op;
    r.addr   = addr;
    r.addr1  = addr1;
    r.data   = data;
    r.be     = be;
    r.expHit = expHit;
    rows.push_back(r);
  endtask

  // ####################################################################
  // Stimulus table
  // ####################################################################

  // Index is addr[7:6] and tag is addr[31:8], so 0x0014 and 0x0114 share a line.
  task automatic buildTable();
    addRow(OpRd1,   32'h0044, 32'h0000, 32'h0000_0000, 4'h0, 1'b0); // Cold misses.
    addRow(OpRd0,   32'h0004, 32'h0000, 32'h0000_0000, 4'h0, 1'b0);
    addRow(OpDual,  32'h0010, 32'h003c, 32'h0000_0000, 4'h0, 1'b1);
    addRow(OpStore, 32'h0014, 32'h0000, 32'hdead_beef, 4'h5, 1'b1); // Partial store hit.
    addRow(OpRd1,   32'h0014, 32'h0000, 32'h0000_0000, 4'h0, 1'b1);
    addRow(OpRd0,   32'h0014, 32'h0000, 32'h0000_0000, 4'h0, 1'b1);
    addRow(OpStore, 32'h0088, 32'h0000, 32'h1234_5678, 4'hc, 1'b0); // Store miss.
    addRow(OpDual,  32'h0088, 32'h008c, 32'h0000_0000, 4'h0, 1'b1);
    addRow(OpRd0,   32'h0114, 32'h0000, 32'h0000_0000, 4'h0, 1'b0); // Dirty eviction.
    addRow(OpRd0,   32'h0014, 32'h0000, 32'h0000_0000, 4'h0, 1'b0);
    addRow(OpRd0,   32'h0288, 32'h0000, 32'h0000_0000, 4'h0, 1'b0);
    addRow(OpRd1,   32'h0088, 32'h0000, 32'h0000_0000, 4'h0, 1'b0);
    addRow(OpDual,  32'h01c0, 32'h0044, 32'h0000_0000, 4'h0, 1'b0); // Port 1 hits during a miss.
    addRow(OpDual,  32'h00d0, 32'h0010, 32'h0000_0000, 4'h0, 1'b0);
    addRow(OpStore, 32'h0048, 32'h0000, 32'hcafe_f00d, 4'hf, 1'b1);
    addRow(OpStore, 32'h0148, 32'h0000, 32'h0bad_c0de, 4'h3, 1'b0); // Store miss over a dirty line.
    addRow(OpDual,  32'h0048, 32'h0098, 32'h0000_0000, 4'h0, 1'b0);
    addRow(OpRd1,   32'h0148, 32'h0000, 32'h0000_0000, 4'h0, 1'b0);
    addRow(OpRd0,   32'h0048, 32'h0000, 32'h0000_0000, 4'h0, 1'b0);
  endtask

  task automatic applyRow(input int idx, input row_t r);
    int    samples;
    int    opsAtStart;
    logic  served;
    logic  observedHit;
    logic  expBusy;
    string label;
    label = $sformatf("row %0d ", idx);
    @(posedge clk);
    #5;
    rd0Req       = (r.op == OpRd0) || (r.op == OpDual);
    rd0Addr      = r.addr;
    rd1Req       = (r.op == OpRd1) || (r.op == OpDual);
    rd1Addr      = (r.op == OpDual) ? r.addr1 : r.addr;
    stReq        = (r.op == OpStore);
    stAddr       = r.addr;
    stData       = r.data;
    stByteEnable = r.be;
    opsAtStart   = memOps;
    samples      = 0;
    served       = 1'b0;
    observedHit  = 1'b0;
    while (!served) begin
      @(negedge clk); // Half a cycle after the inputs changed.
      samples++;
      if (r.op == OpDual) begin
        // Port 1 reads a resident line and has to hit in every cycle.
        checkValue({label, "rd1Hit"}, 32'(rd1Hit), 32'd1);
        checkValue({label, "rd1Data"}, rd1Data, expectedWord(r.addr1));
      end
      case (r.op)
        OpRd1:   served = rd1Hit;
        OpStore: served = stDone;
        default: served = rd0Hit;
      endcase
      // Busy starts the cycle after the request is seen and lasts through Commit.
      expBusy = (samples > 1) && (!served || r.op == OpStore);
      checkValue({label, "busy"}, 32'(busy), 32'(expBusy));
      if (samples == 1 && r.op != OpStore) observedHit = served;
    end
    if (r.op == OpStore) observedHit = (memOps == opsAtStart); // A hit needs no memory traffic.
    checkValue({label, "hit on request"}, 32'(observedHit), 32'(r.expHit));
    case (r.op)
      OpRd1:   checkValue({label, "rd1Data"}, rd1Data, expectedWord(r.addr));
      OpStore: writeShadow(r.addr, r.data, r.be);
      default: checkValue({label, "rd0Data"}, rd0Data, expectedWord(r.addr));
    endcase
    @(posedge clk);
    #5;
    rd0Req = 1'b0;
    rd1Req = 1'b0;
    stReq  = 1'b0;
  endtask

  // ####################################################################
  // Memory model
  // ####################################################################

  initial begin
    logic        isWrite;
    logic [11:0] wordAddr;
    logic [31:0] wrValue;
    int          latency;
    memRdValid = 1'b0;
    memWrAck   = 1'b0;
    memRdData  = '0;
    memOps     = 0;
    for (int n = 0; n < MEM_WORDS; n++) begin
      memWords[n] = fillWord(n);
    end
    forever begin
      @(negedge clk);
      if (memRead || memWrite) begin
        memOps++;
        isWrite  = memWrite;
        wordAddr = memAddr[11:0];
        wrValue  = memWrData;
        latency  = int'($unsigned($random(seed)) % 4) + 1;
        repeat (latency) @(posedge clk);
        #5;
        if (isWrite) begin
          memWords[wordAddr] = wrValue;
          memWrAck = 1'b1;
        end else begin
          memRdData  = memWords[wordAddr];
          memRdValid = 1'b1;
        end
        @(posedge clk);
        #5;
        memWrAck   = 1'b0; // Responses last one cycle.
        memRdValid = 1'b0;
      end
    end
  end

  initial begin
    cycleCount = 0;
    forever begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount > timeoutLimit) begin
        $display("Timeout: the run took more than %0d cycles.", timeoutLimit);
        $display("Result: FAILED");
        $fatal(1, "The DUT stopped responding.");
      end
    end
  end

  initial begin
    rst_n        = 1'b0;
    rd0Req       = 1'b0;
    rd0Addr      = '0;
    rd1Req       = 1'b0;
    rd1Addr      = '0;
    stReq        = 1'b0;
    stAddr       = '0;
    stData       = '0;
    stByteEnable = '0;
    buildTable();
    loadShadow();
    timeoutLimit = rows.size() * 200 + 100;
    repeat (16) @(posedge clk);
    #5;
    rst_n = 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      applyRow(i, rows[i]);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* dualCache.f */
verilog/dualCachePkg.sv
verilog/cacheLine.sv
verilog/lineArray.sv
verilog/missController.sv
verilog/dualCache.sv
verif/dualCacheProps.sv
verif/dualCacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the dualCache testbench with Verilator and runs it.
# The exit status is non-zero when the build fails or the run ends in $fatal.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f dualCache.f \
    --top-module dualCacheTb -o dualCacheSim &&
  ./obj_dir/dualCacheSim ||
  { echo "dualCache simulation did not pass."; exit 1; }
